//--- files.f
hw/tmu_pkg.sv
hw/tmu_vdiv_if.sv
hw/tmu_vdiv.sv
hw/tmu_geninterp.sv
hw/tmu_vinterp.sv
hw/tmu_vscan.sv
bench/tmu_vscan_asserts.sv
bench/tmu_vscan_tb.sv

//--- Makefile
# Verilator build and run of the vertical scan stage testbench

VERILATOR ?= verilator
TOP       ?= tmu_vscan_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tmu_vscan_tb.sv
// Testbench for the vertical scan stage
// Random columns from an LFSR, every output point checked against a model

module tmu_vscan_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int COLUMNS = 40;
	localparam int WATCHDOG_CYCLES = 10 + COLUMNS * (16 * 8 + 40);
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	typedef struct packed {
		tmu_pkg::tex_coord_t ax, ay, bx, by, cx, cy, dx, dy;
		tmu_pkg::scr_coord_t drx, dry;
		tmu_pkg::square_t squareh;
	} column_t;

	logic sys_clk, sys_rst, busy;
	logic in_stb, in_ack, out_stb, out_ack;
	tmu_pkg::tex_coord_t ax, ay, bx, by, cx, cy, dx, dy;
	tmu_pkg::tex_coord_t tsx, tsy, tex, tey;
	tmu_pkg::scr_coord_t drx, dry, x, y;
	tmu_pkg::square_t squareh;

	logic [31:0] lfsr_state;
	column_t cur_col;
	column_t expected_q[$];
	int accepted, issued, gap, pt_idx;
	logic col_taken, stb_pending, was_waiting;
	logic [95:0] held_outputs;

	tmu_vscan u_tmu_vscan (
		.sys_clk (sys_clk), .sys_rst (sys_rst), .busy (busy),
		.in_stb  (in_stb), .in_ack (in_ack),
		.ax (ax), .ay (ay), .bx (bx), .by (by), .cx (cx), .cy (cy), .dx (dx), .dy (dy),
		.drx (drx), .dry (dry), .squareh (squareh),
		.out_stb (out_stb), .out_ack (out_ack), .x (x), .y (y),
		.tsx (tsx), .tsy (tsy), .tex (tex), .tey (tey)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
		else report_failure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_take(input int bits);
		logic [31:0] v;
		logic lsb;
		v = '0;
		for (int i = 0; i < bits; i++) begin
			lsb = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb)
				lfsr_state = lfsr_state ^ LFSR_TAPS;
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	// start +/- (q*k + floor(r*k/h)), q and r from |stop - start| / h
	function automatic tmu_pkg::tex_coord_t expected_coord(input tmu_pkg::tex_coord_t start,
		input tmu_pkg::tex_coord_t stop, input int k, input int h);
		int mag, q, r, step;
		mag = (stop >= start) ? int'(stop) - int'(start) : int'(start) - int'(stop);
		q = mag / h;
		r = mag % h;
		step = q * k + (r * k) / h;
		if (stop >= start)
			return tmu_pkg::tex_coord_t'(int'(start) + step);
		else
			return tmu_pkg::tex_coord_t'(int'(start) - step);
	endfunction

	task automatic new_column();
		cur_col.ax = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.ay = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.bx = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.by = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.cx = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.cy = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.dx = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.dy = tmu_pkg::tex_coord_t'(lfsr_take(18));
		cur_col.drx = tmu_pkg::scr_coord_t'(lfsr_take(12));
		cur_col.dry = tmu_pkg::scr_coord_t'(lfsr_take(12));
		cur_col.squareh = tmu_pkg::square_t'(lfsr_take(4) + 32'd1);
		{ax, ay, bx, by, cx, cy, dx, dy} <= {cur_col.ax, cur_col.ay, cur_col.bx, cur_col.by,
			cur_col.cx, cur_col.cy, cur_col.dx, cur_col.dy};
		{drx, dry, squareh} <= {cur_col.drx, cur_col.dry, cur_col.squareh};
		in_stb <= 1'b1;
	endtask

	// ####################
	// Per cycle stimulus and checks
	// ####################

	task automatic drive_cycle();
		out_ack <= lfsr_take(2) != 32'd0;
		if (col_taken) begin
			in_stb <= 1'b0;
			col_taken = 1'b0;
			stb_pending = 1'b0;
			gap = int'(lfsr_take(2));
		end else if (!stb_pending && issued < COLUMNS) begin
			if (gap == 0) begin
				new_column();
				issued++;
				stb_pending = 1'b1;
			end else begin
				gap--;
			end
		end
	endtask

	task automatic check_point();
		column_t c;
		int h;
		assert (expected_q.size() != 0)
		else report_failure("output point appeared with no column accepted");
		c = expected_q[0];
		h = int'(c.squareh);
		check_value("x", 32'(x), 32'(c.drx));
		check_value("y", 32'(y), 32'(tmu_pkg::scr_coord_t'(int'(c.dry) + pt_idx)));
		check_value("tsx", 32'(tsx), 32'(expected_coord(c.ax, c.cx, pt_idx, h)));
		check_value("tsy", 32'(tsy), 32'(expected_coord(c.ay, c.cy, pt_idx, h)));
		check_value("tex", 32'(tex), 32'(expected_coord(c.bx, c.dx, pt_idx, h)));
		check_value("tey", 32'(tey), 32'(expected_coord(c.by, c.dy, pt_idx, h)));
		pt_idx++;
		if (pt_idx == h) begin
			void'(expected_q.pop_front());
			pt_idx = 0;
		end
	endtask

	// Values seen here are the ones the next rising edge takes
	task automatic sample_cycle();
		if (was_waiting) begin
			assert (out_stb)
			else report_failure("out_stb dropped while out_ack was low");
			assert ({x, y, tsx, tsy, tex, tey} == held_outputs)
			else report_failure("output point changed while out_ack was low");
		end
		was_waiting = out_stb && !out_ack;
		held_outputs = {x, y, tsx, tsy, tex, tey};
		if (out_stb && out_ack)
			check_point();
		if (in_stb && in_ack) begin
			expected_q.push_back(cur_col);
			accepted++;
			col_taken = 1'b1;
		end
	endtask

	initial begin
		lfsr_state = 32'd776;
		accepted = 0;
		issued = 0;
		gap = 0;
		pt_idx = 0;
		col_taken = 1'b0;
		stb_pending = 1'b0;
		was_waiting = 1'b0;
		sys_rst <= 1'b1;
		in_stb <= 1'b0;
		out_ack <= 1'b0;
		{ax, ay, bx, by, cx, cy, dx, dy} <= '0;
		{drx, dry} <= '0;
		squareh <= 11'd1;
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(negedge sys_clk);
		check_value("in_ack", 32'(in_ack), 32'd1);
		check_value("out_stb", 32'(out_stb), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		// Run until the last column is taken and the DUT goes idle
		while (accepted < COLUMNS || col_taken || busy) begin
			@(posedge sys_clk);
			drive_cycle();
			@(negedge sys_clk);
			sample_cycle();
		end
		check_value("out_stb", 32'(out_stb), 32'd0);
		if (expected_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			report_failure("busy dropped while points of accepted columns were still missing");
		end
	end

	// Bound checker on the DUT
	initial begin
		wait (u_tmu_vscan.u_asserts.fail_count != 0);
		report_failure("a bound assertion on the DUT failed");
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		report_failure("watchdog expired before all columns were checked");
	end

endmodule

//--- bench/tmu_vscan_asserts.sv
// Bound checks on the vertical scan stage
// Divider latency, output hold under back-pressure, y stepping

module tmu_vscan_asserts (
	input logic                sys_clk,
	input logic                sys_rst,
	input logic                in_stb,
	input logic                in_ack,
	input logic                vd_stb,
	input logic                out_stb,
	input logic                out_ack,
	input tmu_pkg::scr_coord_t y,
	input logic [95:0]         out_data
);
	timeunit 1ns;
	timeprecision 100ps;

	// Count of failed assertions
	int fail_count = 0;

	// Divided column is offered a fixed time after acceptance
	a_div_latency: assert property (@(posedge sys_clk) disable iff (sys_rst)
		in_stb && in_ack |-> ##(tmu_pkg::DIV_STEPS + 1) vd_stb)
		else begin
			$error("divided column not offered in time");
			fail_count++;
		end

	// Point waits unchanged for out_ack
	a_out_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb && !out_ack |=> out_stb && $stable(out_data))
		else begin
			$error("output point not held under back-pressure");
			fail_count++;
		end

	// Still busy after a transfer means the column goes on
	a_y_step: assert property (@(posedge sys_clk) disable iff (sys_rst)
		out_stb && out_ack |=> !out_stb || y == tmu_pkg::scr_coord_t'($past(y) + 1'b1))
		else begin
			$error("y did not advance by one");
			fail_count++;
		end

endmodule

bind tmu_vscan tmu_vscan_asserts u_asserts (
	.sys_clk  (sys_clk),
	.sys_rst  (sys_rst),
	.in_stb   (in_stb),
	.in_ack   (in_ack),
	.vd_stb   (u_vd_if.stb),
	.out_stb  (out_stb),
	.out_ack  (out_ack),
	.y        (y),
	.out_data ({x, y, tsx, tsy, tex, tey})
);

//--- hw/tmu_vscan.sv
// Vertical scan stage of the texture mapping unit
// Setup divider feeding the vertical interpolator, two columns in flight

module tmu_vscan (
	input  logic                sys_clk,
	input  logic                sys_rst,
	output logic                busy,
	input  logic                in_stb,
	output logic                in_ack,
	input  tmu_pkg::tex_coord_t ax,
	input  tmu_pkg::tex_coord_t ay,
	input  tmu_pkg::tex_coord_t bx,
	input  tmu_pkg::tex_coord_t by,
	input  tmu_pkg::tex_coord_t cx,
	input  tmu_pkg::tex_coord_t cy,
	input  tmu_pkg::tex_coord_t dx,
	input  tmu_pkg::tex_coord_t dy,
	input  tmu_pkg::scr_coord_t drx,
	input  tmu_pkg::scr_coord_t dry,
	input  tmu_pkg::square_t    squareh,
	output logic                out_stb,
	input  logic                out_ack,
	output tmu_pkg::scr_coord_t x,
	output tmu_pkg::scr_coord_t y,
	output tmu_pkg::tex_coord_t tsx,
	output tmu_pkg::tex_coord_t tsy,
	output tmu_pkg::tex_coord_t tex,
	output tmu_pkg::tex_coord_t tey
);

	logic div_busy;
	logic interp_busy;

	tmu_vdiv_if u_vd_if ();

	tmu_vdiv u_vdiv (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.busy    (div_busy),
		.in_stb  (in_stb),
		.in_ack  (in_ack),
		.ax      (ax),
		.ay      (ay),
		.bx      (bx),
		.by      (by),
		.cx      (cx),
		.cy      (cy),
		.dx      (dx),
		.dy      (dy),
		.drx     (drx),
		.dry     (dry),
		.squareh (squareh),
		.vd      (u_vd_if.src)
	);

	tmu_vinterp u_vinterp (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.busy    (interp_busy),
		.vd      (u_vd_if.dst),
		.out_stb (out_stb),
		.out_ack (out_ack),
		.x       (x),
		.y       (y),
		.tsx     (tsx),
		.tsy     (tsy),
		.tex     (tex),
		.tey     (tey)
	);

	// Work held in either stage
	assign busy = div_busy | interp_busy;

endmodule

//--- hw/tmu_vinterp.sv
// Vertical interpolator
// Loads a divided column and emits squareh points down both edges,
// one per output handshake

module tmu_vinterp (
	input  logic                sys_clk,
	input  logic                sys_rst,
	output logic                busy,
	tmu_vdiv_if.dst             vd,
	output logic                out_stb,
	input  logic                out_ack,
	output tmu_pkg::scr_coord_t x,
	output tmu_pkg::scr_coord_t y,
	output tmu_pkg::tex_coord_t tsx,
	output tmu_pkg::tex_coord_t tsy,
	output tmu_pkg::tex_coord_t tex,
	output tmu_pkg::tex_coord_t tey
);

	typedef enum logic {
		VI_IDLE,
		VI_BUSY
	} vi_state_t;

	vi_state_t state;
	logic load;
	logic next_point;
	logic last_point;
	tmu_pkg::square_t remaining;
	tmu_pkg::square_t squareh_r;

	// Channels: left x, left y, right x, right y
	tmu_pkg::tex_coord_t init_v[4];
	logic pos_v[4];
	tmu_pkg::quot_t q_v[4];
	tmu_pkg::quot_t r_v[4];
	logic pos_r[4];
	tmu_pkg::quot_t q_r[4];
	tmu_pkg::quot_t r_r[4];
	tmu_pkg::tex_coord_t o_v[4];

	always_comb begin
		init_v = '{vd.ax, vd.ay, vd.bx, vd.by};
		pos_v = '{vd.cx_positive, vd.cy_positive, vd.dx_positive, vd.dy_positive};
		q_v = '{vd.cx_q, vd.cy_q, vd.dx_q, vd.dy_q};
		r_v = '{vd.cx_r, vd.cy_r, vd.dx_r, vd.dy_r};
	end

	// ####################
	// Datapath
	// ####################

	always_ff @(posedge sys_clk) begin
		if (load) begin
			x <= vd.drx;
			squareh_r <= vd.squareh;
			for (int i = 0; i < 4; i++) begin
				pos_r[i] <= pos_v[i];
				q_r[i] <= q_v[i];
				r_r[i] <= r_v[i];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			y <= vd.dry;
			remaining <= vd.squareh - 1'b1;
		end else if (next_point) begin
			y <= y + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	for (genvar i = 0; i < 4; i++) begin : g_ch
		tmu_geninterp u_interp (
			.sys_clk    (sys_clk),
			.load       (load),
			.next_point (next_point),
			.init       (init_v[i]),
			.positive   (pos_r[i]),
			.q          (q_r[i]),
			.r          (r_r[i]),
			.divisor    (squareh_r),
			.o          (o_v[i])
		);
	end

	assign tsx = o_v[0];
	assign tsy = o_v[1];
	assign tex = o_v[2];
	assign tey = o_v[3];

	// ####################
	// Controller
	// ####################

	assign last_point = remaining == '0;
	assign load = (state == VI_IDLE) && vd.stb;
	// Last point transfer only ends the column
	assign next_point = (state == VI_BUSY) && out_ack && !last_point;

	assign vd.ack = state == VI_IDLE;
	assign out_stb = state == VI_BUSY;
	assign busy = state == VI_BUSY;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= VI_IDLE;
		end else begin
			case (state)
				VI_IDLE: begin
					if (vd.stb)
						state <= VI_BUSY;
				end
				VI_BUSY: begin
					if (out_ack && last_point)
						state <= VI_IDLE;
				end
				default: state <= VI_IDLE;
			endcase
		end
	end

endmodule

//--- hw/tmu_geninterp.sv
// Linear interpolator for one texture coordinate
// Steps by q per point and carries the remainder in an error accumulator

module tmu_geninterp (
	input  logic                sys_clk,
	input  logic                load,
	input  logic                next_point,
	input  tmu_pkg::tex_coord_t init,
	input  logic                positive,
	input  tmu_pkg::quot_t      q,
	input  tmu_pkg::quot_t      r,
	input  tmu_pkg::square_t    divisor,
	output tmu_pkg::tex_coord_t o
);

	tmu_pkg::quot_t err;
	logic [17:0] err_sum;
	logic carry;
	tmu_pkg::tex_coord_t delta;

	always_comb begin
		err_sum = {1'b0, err} + {1'b0, r};
		// Accumulated fraction reached a whole step
		carry = err_sum >= 18'(divisor);
		delta = tmu_pkg::tex_coord_t'(q) + tmu_pkg::tex_coord_t'(carry);
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			o <= init;
			err <= '0;
		end else if (next_point) begin
			if (positive)
				o <= o + delta;
			else
				o <= o - delta;
			if (carry)
				err <= tmu_pkg::quot_t'(err_sum - 18'(divisor));
			else
				err <= tmu_pkg::quot_t'(err_sum);
		end
	end

endmodule

//--- hw/tmu_vdiv.sv
// Column setup divider
// Splits the four edge differences into sign and magnitude, then runs
// a restoring division by squareh on all four channels in parallel

module tmu_vdiv (
	input  logic                sys_clk,
	input  logic                sys_rst,
	output logic                busy,
	input  logic                in_stb,
	output logic                in_ack,
	input  tmu_pkg::tex_coord_t ax,
	input  tmu_pkg::tex_coord_t ay,
	input  tmu_pkg::tex_coord_t bx,
	input  tmu_pkg::tex_coord_t by,
	input  tmu_pkg::tex_coord_t cx,
	input  tmu_pkg::tex_coord_t cy,
	input  tmu_pkg::tex_coord_t dx,
	input  tmu_pkg::tex_coord_t dy,
	input  tmu_pkg::scr_coord_t drx,
	input  tmu_pkg::scr_coord_t dry,
	input  tmu_pkg::square_t    squareh,
	tmu_vdiv_if.src             vd
);

	localparam int STEP_W = $clog2(tmu_pkg::DIV_STEPS);

	tmu_pkg::div_state_t state;
	logic [STEP_W-1:0] step;
	logic load;

	// Registered column
	tmu_pkg::tex_coord_t ax_r;
	tmu_pkg::tex_coord_t ay_r;
	tmu_pkg::tex_coord_t bx_r;
	tmu_pkg::tex_coord_t by_r;
	tmu_pkg::scr_coord_t drx_r;
	tmu_pkg::scr_coord_t dry_r;
	tmu_pkg::square_t squareh_r;

	// Channel order: cx, cy, dx, dy
	tmu_pkg::tex_coord_t start_v[4];
	tmu_pkg::tex_coord_t end_v[4];
	logic pos_v[4];
	tmu_pkg::tex_coord_t mag_v[4];
	logic [17:0] shifted_v[4];
	logic [17:0] trial_v[4];
	logic fits_v[4];

	logic pos_r[4];
	tmu_pkg::quot_t num_r[4];
	tmu_pkg::quot_t rem_r[4];

	assign in_ack = state == tmu_pkg::DIV_IDLE;
	assign busy = state != tmu_pkg::DIV_IDLE;
	assign load = in_stb && in_ack;

	// ####################
	// Datapath
	// ####################

	always_comb begin
		start_v = '{ax, ay, bx, by};
		end_v = '{cx, cy, dx, dy};
		for (int i = 0; i < 4; i++) begin
			pos_v[i] = end_v[i] >= start_v[i];
			mag_v[i] = pos_v[i] ? end_v[i] - start_v[i] : start_v[i] - end_v[i];
			// Bring down the next dividend bit
			shifted_v[i] = {rem_r[i], num_r[i][16]};
			fits_v[i] = shifted_v[i] >= 18'(squareh_r);
			trial_v[i] = shifted_v[i] - 18'(squareh_r);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			ax_r <= ax;
			ay_r <= ay;
			bx_r <= bx;
			by_r <= by;
			drx_r <= drx;
			dry_r <= dry;
			squareh_r <= squareh;
			for (int i = 0; i < 4; i++) begin
				pos_r[i] <= pos_v[i];
				num_r[i] <= mag_v[i][16:0];
				// MSB starts in the remainder, quotient fits 17 bits for squareh > 1
				rem_r[i] <= tmu_pkg::quot_t'(mag_v[i][17]);
			end
		end else if (state == tmu_pkg::DIV_RUN) begin
			for (int i = 0; i < 4; i++) begin
				// Quotient bits shift in behind the dividend
				num_r[i] <= {num_r[i][15:0], fits_v[i]};
				rem_r[i] <= fits_v[i] ? trial_v[i][16:0] : shifted_v[i][16:0];
			end
		end
	end

	// ####################
	// Controller
	// ####################

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::DIV_IDLE;
			step <= '0;
		end else begin
			case (state)
				tmu_pkg::DIV_IDLE: begin
					if (in_stb) begin
						state <= tmu_pkg::DIV_RUN;
						step <= '0;
					end
				end
				tmu_pkg::DIV_RUN: begin
					step <= step + 1'b1;
					if (step == STEP_W'(tmu_pkg::DIV_STEPS - 1))
						state <= tmu_pkg::DIV_DONE;
				end
				tmu_pkg::DIV_DONE: begin
					if (vd.ack)
						state <= tmu_pkg::DIV_IDLE;
				end
				default: state <= tmu_pkg::DIV_IDLE;
			endcase
		end
	end

	// Result towards the interpolator
	assign vd.stb = state == tmu_pkg::DIV_DONE;
	assign vd.ax = ax_r;
	assign vd.ay = ay_r;
	assign vd.bx = bx_r;
	assign vd.by = by_r;
	assign vd.cx_positive = pos_r[0];
	assign vd.cx_q = num_r[0];
	assign vd.cx_r = rem_r[0];
	assign vd.cy_positive = pos_r[1];
	assign vd.cy_q = num_r[1];
	assign vd.cy_r = rem_r[1];
	assign vd.dx_positive = pos_r[2];
	assign vd.dx_q = num_r[2];
	assign vd.dx_r = rem_r[2];
	assign vd.dy_positive = pos_r[3];
	assign vd.dy_q = num_r[3];
	assign vd.dy_r = rem_r[3];
	assign vd.drx = drx_r;
	assign vd.dry = dry_r;
	assign vd.squareh = squareh_r;

endmodule

//--- hw/tmu_vdiv_if.sv
// Divided column from the setup divider to the vertical interpolator
// Strobe/acknowledge handshake, data stable while stb waits for ack

interface tmu_vdiv_if;
	logic stb;
	logic ack;

	// Edge start points
	tmu_pkg::tex_coord_t ax;
	tmu_pkg::tex_coord_t ay;
	tmu_pkg::tex_coord_t bx;
	tmu_pkg::tex_coord_t by;

	// Per channel step: direction, quotient, remainder
	logic cx_positive;
	tmu_pkg::quot_t cx_q;
	tmu_pkg::quot_t cx_r;
	logic cy_positive;
	tmu_pkg::quot_t cy_q;
	tmu_pkg::quot_t cy_r;
	logic dx_positive;
	tmu_pkg::quot_t dx_q;
	tmu_pkg::quot_t dx_r;
	logic dy_positive;
	tmu_pkg::quot_t dy_q;
	tmu_pkg::quot_t dy_r;

	tmu_pkg::scr_coord_t drx;
	tmu_pkg::scr_coord_t dry;
	tmu_pkg::square_t squareh;

	modport src (
		output stb, ax, ay, bx, by,
		output cx_positive, cx_q, cx_r, cy_positive, cy_q, cy_r,
		output dx_positive, dx_q, dx_r, dy_positive, dy_q, dy_r,
		output drx, dry, squareh,
		input ack
	);

	modport dst (
		input stb, ax, ay, bx, by,
		input cx_positive, cx_q, cx_r, cy_positive, cy_q, cy_r,
		input dx_positive, dx_q, dx_r, dy_positive, dy_q, dy_r,
		input drx, dry, squareh,
		output ack
	);
endinterface

//--- hw/tmu_pkg.sv
// Texture mapping unit, vertical scan stage
// Shared widths and the divider state encoding

package tmu_pkg;

	// ####################
	// Widths
	// ####################

	// Texture coordinate, unsigned fixed point
	typedef logic [17:0] tex_coord_t;

	// Screen coordinate
	typedef logic [11:0] scr_coord_t;

	// Square height in points
	typedef logic [10:0] square_t;

	// Magnitude of a quotient or remainder
	typedef logic [16:0] quot_t;

	// ####################
	// Divider
	// ####################

	// Quotient bits, one per cycle
	localparam int DIV_STEPS = 17;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

endpackage
